// File: Makefile
TOP := fv_mem_tb
BIN := obj_dir/V$(TOP)

.PHONY: run clean

run: $(BIN)
	@out="$$(./$(BIN) +verilator+error+limit+1000)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "all tests passed"

$(BIN): fv_mem.f $(shell cat fv_mem.f)
	verilator --binary --timing --assert --top-module $(TOP) -f fv_mem.f

clean:
	rm -rf obj_dir

// File: bench/fv_mem_clock_gen.sv
// Clock and synchronous reset generator for the testbench
`timescale 1ns/1ps
`default_nettype none

module fv_mem_clock_gen #(
    parameter int period       = 20,
    parameter int reset_cycles = 3
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

    initial begin
        reset = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        reset <= 1'b0;    // Released after the last reset edge
    end

endmodule

`default_nettype wire

// File: bench/fv_mem_properties.sv
// Concurrent protocol assertions on the merged stream and bank busy, bound to the top level
`timescale 1ns/1ps
`default_nettype none

module fv_mem_properties (
    input  logic                    clk,
    input  logic                    reset,
    input  fv_mem_pkg::fv_word_t    out,
    input  fv_mem_pkg::fv_word_t    stream0,
    input  fv_mem_pkg::fv_word_t    stream1,
    input  logic [1:0]              busy
);

    int unsigned fail_count = 0;
    logic        pkt_open;    // A packet on out has started and not yet ended

    always_ff @(posedge clk) begin
        if (reset) begin
            pkt_open <= 1'b0;
        end else if (out.valid) begin
            pkt_open <= !out.eos;
        end
    end

    no_valid_in_reset: assert property (@(posedge clk)
        reset |=> !out.valid && !stream0.valid && !stream1.valid)
        else begin
            fail_count++;
            $error("A valid word was issued during reset");
        end

    sos_only_when_closed: assert property (@(posedge clk) disable iff (reset)
        out.valid && out.sos |-> !pkt_open)
        else begin
            fail_count++;
            $error("A packet started on out while another was still open");
        end

    packet_contiguous: assert property (@(posedge clk) disable iff (reset)
        out.valid && !out.eos |=> out.valid)
        else begin
            fail_count++;
            $error("Valid dropped on out inside a packet");
        end

    busy0_after_eos: assert property (@(posedge clk) disable iff (reset)
        $fell(busy[0]) |-> stream0.valid && stream0.eos)
        else begin
            fail_count++;
            $error("Bank 0 busy fell without an eos word");
        end

    busy1_after_eos: assert property (@(posedge clk) disable iff (reset)
        $fell(busy[1]) |-> stream1.valid && stream1.eos)
        else begin
            fail_count++;
            $error("Bank 1 busy fell without an eos word");
        end

endmodule

bind fv_mem_top fv_mem_properties props (
    .clk     (clk),
    .reset   (reset),
    .out     (out),
    .stream0 (stream0),
    .stream1 (stream1),
    .busy    (busy)
);

`default_nettype wire

// File: bench/fv_mem_tb.sv
// Testbench for the feature-vector memory: stimulus, reference image, expected packets, checks
`timescale 1ns/1ps
`default_nettype none

module fv_mem_tb;

    localparam int n_reads     = 44;
    localparam int total_words = 2 * 256 + 1 + n_reads * 32;    // Upper bound over all tests

    logic                  clk;
    logic                  reset;
    fv_mem_pkg::fv_write_t wr;
    fv_mem_pkg::fv_req_t   req;
    fv_mem_pkg::fv_word_t  out;
    logic [1:0]            busy;

    fv_mem_pkg::fv_word_t  exp_q0 [$];
    fv_mem_pkg::fv_word_t  exp_q1 [$];
    fv_mem_pkg::fv_word_t  exp_word;
    logic [15:0]           image [2][256];    // Reference copy of both banks
    int                    odd_lens [5] = '{1, 3, 2, 5, 63};
    int                    seed = 67533;
    int                    cycle = 0;
    int                    errors = 0;
    int                    checks = 0;
    int                    busy_due [2] = '{-1, -1};
    int                    lat_edge = 0;
    bit                    lat_armed = 1'b0;
    bit                    fair_on = 1'b0;
    bit                    fair_seen = 1'b0;
    logic                  fair_prev = 1'b0;
    string                 test_name = "reset";

    fv_mem_clock_gen #(.period(20), .reset_cycles(3)) clock_gen (.clk(clk), .reset(reset));

    fv_mem_top dut (.clk(clk), .reset(reset), .wr(wr), .req(req), .out(out), .busy(busy));

    function automatic int random_in_range(input int lo, input int hi);
        logic [31:0] r;
        r = $random(seed);
        return lo + int'(r % 32'(hi - lo + 1));
    endfunction

    // Words of one packet, two elements per word, odd tail padded with zero
    task automatic expect_packet(input logic bank, input logic [7:0] addr, input int len,
                                 input logic [2:0] tag);
        fv_mem_pkg::fv_word_t w;
        int                   n;
        n = (len + 1) / 2;
        for (int i = 0; i < n; i++) begin
            w       = '0;
            w.valid = 1'b1;
            w.sos   = (i == 0);
            w.eos   = (i == n - 1);
            w.bank  = bank;
            w.tag   = tag;
            w.data  = image[bank][addr + 8'(i)];
            if (i == n - 1 && len % 2 == 1) begin
                w.data[15:8] = 8'h00;
            end
            if (bank) begin
                exp_q1.push_back(w);
            end else begin
                exp_q0.push_back(w);
            end
        end
    endtask

    task automatic write_stream(input logic bank, input logic [7:0] base, input int n);
        for (int i = 0; i < n; i++) begin
            @(negedge clk);
            checks++;
            assert (busy == 2'b00) else begin
                errors++;
                $display("Busy is high during a write stream to bank %0d", bank);
            end
            wr.sos  = (i == 0);
            wr.eos  = (i == n - 1);
            wr.bank = bank;
            wr.addr = base + 8'(i);
            wr.data = 16'($random(seed));
            image[bank][wr.addr] = wr.data;
        end
        @(negedge clk);
        wr = '0;
    endtask

    task automatic send_req(input logic bank, input logic [7:0] addr, input int len);
        @(negedge clk);
        req.valid = 1'b1;
        req.bank  = bank;
        req.addr  = addr;
        req.len   = 6'(len);
        req.tag   = 3'($random(seed));
        busy_due[bank] = cycle + 2;    // Busy seen one edge after the sampling edge
        expect_packet(bank, addr, len, req.tag);
    endtask

    task automatic end_req();
        @(negedge clk);
        req = '0;
    endtask

    task automatic wait_idle();
        @(negedge clk);
        while (busy != 2'b00) @(negedge clk);
    endtask

    // At most limit words still expected on out
    task automatic wait_backlog(input int limit);
        while (exp_q0.size() + exp_q1.size() > limit) @(negedge clk);
    endtask

    task automatic read_one(input logic bank, input logic [7:0] addr, input int len);
        send_req(bank, addr, len);
        end_req();
        wait_idle();
    endtask

    always @(posedge clk) cycle <= cycle + 1;

    always @(negedge clk) begin
        for (int b = 0; b < 2; b++) begin
            if (cycle == busy_due[b]) begin
                checks++;
                assert (busy[b]) else begin
                    errors++;
                    $display("Busy did not rise after a request to bank %0d", b);
                end
            end
        end
        if (!reset && out.valid) begin
            if ((out.bank ? exp_q1.size() : exp_q0.size()) == 0) begin
                errors++;
                $display("Unexpected word from bank %0d on out in %s", out.bank, test_name);
            end else begin
                if (out.bank) begin
                    exp_word = exp_q1.pop_front();
                end else begin
                    exp_word = exp_q0.pop_front();
                end
                checks++;
                assert (out == exp_word) else begin
                    errors++;
                    $display("Mismatch %s: expected %h, actual %h", test_name, exp_word, out);
                end
            end
            if (out.sos && lat_armed) begin
                lat_armed = 1'b0;
                checks++;
                assert (cycle - lat_edge == 3) else begin
                    errors++;
                    $display("Mismatch %s: expected 3, actual %0d", test_name, cycle - lat_edge);
                end
            end
            if (out.sos && fair_on) begin
                if (fair_seen) begin
                    checks++;
                    assert (out.bank != fair_prev) else begin
                        errors++;
                        $display("Mismatch %s: expected bank %0d, actual bank %0d",
                                 test_name, !fair_prev, out.bank);
                    end
                end
                fair_prev = out.bank;
                fair_seen = 1'b1;
            end
        end
    end

    initial begin
        repeat (total_words * 4 + 200) @(posedge clk);
        $display("Timeout after %0d cycles, %0d checks, %0d errors", cycle, checks, errors);
        $display("tests failed");
        $finish;
    end

    initial begin
        wr  = '0;
        req = '0;
        @(negedge clk);
        while (reset) @(negedge clk);
        checks++;
        assert (busy == 2'b00) else begin
            errors++;
            $display("Busy is high after reset");
        end

        test_name = "write_read";
        write_stream(1'b0, 8'd0, 256);
        write_stream(1'b1, 8'd0, 256);
        write_stream(1'b1, 8'd5, 1);    // Single word with sos and eos
        read_one(1'b0, 8'd0, 63);
        read_one(1'b1, 8'd0, 12);
        wait_backlog(0);

        test_name = "odd_length";
        for (int i = 0; i < 10; i++) begin
            read_one(1'(i % 2), 8'(random_in_range(0, 255)), odd_lens[i / 2]);
        end
        wait_backlog(0);

        test_name = "latency";
        for (int i = 0; i < 4; i++) begin
            send_req(1'(i % 2), 8'(random_in_range(0, 255)), random_in_range(1, 63));
            lat_edge  = cycle + 1;
            lat_armed = 1'b1;
            end_req();
            wait_idle();
            wait_backlog(0);
            checks++;
            assert (!lat_armed) else begin
                errors++;
                $display("No packet reached out in %s", test_name);
            end
        end

        test_name = "both_banks";
        for (int i = 0; i < 8; i++) begin
            wait_backlog(16);
            send_req(1'b0, 8'(random_in_range(0, 255)), random_in_range(1, 16));
            send_req(1'b1, 8'(random_in_range(0, 255)), random_in_range(1, 16));
            end_req();
            wait_idle();
        end
        wait_backlog(0);

        test_name = "fairness";
        fair_on   = 1'b1;
        for (int i = 0; i < 6; i++) begin
            wait_backlog(24);    // Lets packets pile up in both FIFOs
            send_req(1'b0, 8'(random_in_range(0, 255)), 16);
            send_req(1'b1, 8'(random_in_range(0, 255)), 16);
            end_req();
            wait_idle();
        end
        wait_backlog(0);
        fair_on = 1'b0;

        errors = errors + int'(dut.props.fail_count);
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: fv_mem.f
hdl/fv_mem_pkg.sv
hdl/fv_bank_sram.sv
hdl/fv_bank_cntl.sv
hdl/fv_stream_merge.sv
hdl/fv_mem_top.sv
bench/fv_mem_clock_gen.sv
bench/fv_mem_properties.sv
bench/fv_mem_tb.sv

// File: hdl/fv_bank_cntl.sv
// Bank controller: write streams into the SRAM, read requests out as word streams
`timescale 1ns/1ps
`default_nettype none

module fv_bank_cntl #(
    parameter bit bank_id = 1'b0
) (
    input  logic                                clk,
    input  logic                                reset,
    input  fv_mem_pkg::fv_write_t               wr,
    input  fv_mem_pkg::fv_req_t                 req,
    input  logic [fv_mem_pkg::word_width-1:0]   rdata,
    output fv_mem_pkg::sram_port_t              sram,
    output fv_mem_pkg::fv_word_t                stream,
    output logic                                busy
);

    localparam int pad_width = fv_mem_pkg::word_width - fv_mem_pkg::elem_width;

    fv_mem_pkg::bank_state_t state;

    logic [fv_mem_pkg::len_width:0]     cnt;        // Elements covered by the reads issued
    logic [fv_mem_pkg::len_width:0]     cnt_next;
    logic [fv_mem_pkg::len_width-1:0]   len_q;
    logic [fv_mem_pkg::tag_width-1:0]   tag_q;
    logic                               iss_sos;    // Flags of the read now on the SRAM port
    logic                               iss_eos;
    logic                               rd_vld;     // Read data present on rdata
    logic                               rd_sos;
    logic                               rd_eos;
    logic                               wr_hit;
    logic                               req_hit;
    logic                               start_read;
    logic                               more;

    assign wr_hit     = wr.sos && (wr.bank == bank_id);
    assign req_hit    = req.valid && (req.bank == bank_id);
    assign start_read = (state == fv_mem_pkg::bank_idle) && !wr_hit && req_hit;
    assign cnt_next   = cnt + 2'd2;
    assign more       = cnt < {1'b0, len_q};

    // Request payload, held until the packet is out
    always_ff @(posedge clk) begin
        if (start_read) begin
            len_q <= req.len;
            tag_q <= req.tag;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= fv_mem_pkg::bank_idle;
            sram    <= '{cen: 1'b1, wen: 1'b1, default: '0};
            cnt     <= '0;
            iss_sos <= 1'b0;
            iss_eos <= 1'b0;
            rd_vld  <= 1'b0;
            rd_sos  <= 1'b0;
            rd_eos  <= 1'b0;
            stream  <= '0;
            busy    <= 1'b0;
        end else begin
            rd_vld   <= !sram.cen && sram.wen;
            rd_sos   <= iss_sos;
            rd_eos   <= iss_eos;
            sram.cen <= 1'b1;
            sram.wen <= 1'b1;
            iss_sos  <= 1'b0;
            iss_eos  <= 1'b0;

            stream.valid <= rd_vld;
            stream.sos   <= rd_vld && rd_sos;
            stream.eos   <= rd_vld && rd_eos;
            stream.bank  <= bank_id;
            stream.tag   <= tag_q;
            if (rd_eos && len_q[0]) begin
                // Odd tail: last element in the low byte
                stream.data <= {{pad_width{1'b0}}, rdata[fv_mem_pkg::elem_width-1:0]};
            end else begin
                stream.data <= rdata;
            end

            case (state)
                fv_mem_pkg::bank_idle: begin
                    if (wr_hit) begin
                        sram <= '{cen: 1'b0, wen: 1'b0, addr: wr.addr, data: wr.data};
                        if (!wr.eos) begin
                            state <= fv_mem_pkg::bank_write;    // Single-word stream stays idle
                        end
                    end else if (start_read) begin
                        sram.cen  <= 1'b0;
                        sram.addr <= req.addr;
                        cnt       <= 2'd2;
                        iss_sos   <= 1'b1;
                        iss_eos   <= req.len <= 2;
                        state     <= fv_mem_pkg::bank_stream;
                    end
                end
                fv_mem_pkg::bank_write: begin
                    sram <= '{cen: 1'b0, wen: 1'b0, addr: wr.addr, data: wr.data};
                    if (wr.eos) begin
                        state <= fv_mem_pkg::bank_idle;
                    end
                end
                fv_mem_pkg::bank_stream: begin
                    if (more) begin
                        sram.cen  <= 1'b0;
                        sram.addr <= sram.addr + 1'b1;
                        cnt       <= cnt_next;
                        iss_eos   <= cnt_next >= {1'b0, len_q};
                    end
                    busy <= !(rd_vld && rd_eos);
                    if (rd_vld && rd_eos) begin
                        state <= fv_mem_pkg::bank_idle;    // Eos word goes out on this edge
                    end
                end
                default: begin
                    state <= fv_mem_pkg::bank_idle;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hdl/fv_bank_sram.sv
// Behavioural single-port synchronous SRAM for one feature-vector bank
`timescale 1ns/1ps
`default_nettype none

module fv_bank_sram #(
    parameter int depth = 256
) (
    input  logic                                clk,
    input  fv_mem_pkg::sram_port_t              port,
    output logic [fv_mem_pkg::word_width-1:0]   rdata
);

    logic [fv_mem_pkg::word_width-1:0] mem [depth];

    always_ff @(posedge clk) begin
        if (!port.cen) begin
            if (!port.wen) begin
                mem[port.addr] <= port.data;
            end else begin
                rdata <= mem[port.addr];    // Registered read, one cycle after the address
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/fv_mem_pkg.sv
// Shared widths, stream and port structs, and FSM state types of the feature-vector memory
`default_nettype none

package fv_mem_pkg;

    localparam int word_width = 16;   // SRAM word and streamed word
    localparam int elem_width = 8;    // One feature element
    localparam int addr_width = 8;    // Bank word address
    localparam int len_width  = 6;    // Vector length in elements
    localparam int tag_width  = 3;    // Destination PE tag

    // One word of a loader write stream
    typedef struct packed {
        logic                  sos;
        logic                  eos;
        logic                  bank;
        logic [addr_width-1:0] addr;
        logic [word_width-1:0] data;
    } fv_write_t;

    // Read request from the edge-PE scheduler
    typedef struct packed {
        logic                  valid;
        logic                  bank;
        logic [addr_width-1:0] addr;
        logic [len_width-1:0]  len;    // Elements, at least 1
        logic [tag_width-1:0]  tag;
    } fv_req_t;

    typedef struct packed {
        logic                  cen;    // Active low
        logic                  wen;    // Active low
        logic [addr_width-1:0] addr;
        logic [word_width-1:0] data;
    } sram_port_t;

    // Streamed word, used by the banks and by the merged output
    typedef struct packed {
        logic                  valid;
        logic                  sos;
        logic                  eos;
        logic                  bank;
        logic [tag_width-1:0]  tag;
        logic [word_width-1:0] data;
    } fv_word_t;

    typedef enum logic [1:0] {
        bank_idle,
        bank_write,
        bank_stream
    } bank_state_t;

    typedef enum logic {
        merge_pick,
        merge_send
    } merge_state_t;

endpackage

`default_nettype wire

// File: hdl/fv_mem_top.sv
// Feature-vector memory top level: two bank controllers with their SRAMs and the stream merger
`timescale 1ns/1ps
`default_nettype none

module fv_mem_top #(
    parameter int depth      = 256,
    parameter int fifo_depth = 32
) (
    input  logic                    clk,
    input  logic                    reset,
    input  fv_mem_pkg::fv_write_t   wr,
    input  fv_mem_pkg::fv_req_t     req,
    output fv_mem_pkg::fv_word_t    out,
    output logic [1:0]              busy
);

    fv_mem_pkg::sram_port_t             sram_port0;
    fv_mem_pkg::sram_port_t             sram_port1;
    logic [fv_mem_pkg::word_width-1:0]  rdata0;
    logic [fv_mem_pkg::word_width-1:0]  rdata1;
    fv_mem_pkg::fv_word_t               stream0;
    fv_mem_pkg::fv_word_t               stream1;

    // Both controllers see every write and request and filter on bank
    fv_bank_cntl #(
        .bank_id (1'b0)
    ) bank0 (
        .clk    (clk),
        .reset  (reset),
        .wr     (wr),
        .req    (req),
        .rdata  (rdata0),
        .sram   (sram_port0),
        .stream (stream0),
        .busy   (busy[0])
    );

    fv_bank_sram #(
        .depth (depth)
    ) sram0 (
        .clk   (clk),
        .port  (sram_port0),
        .rdata (rdata0)
    );

    fv_bank_cntl #(
        .bank_id (1'b1)
    ) bank1 (
        .clk    (clk),
        .reset  (reset),
        .wr     (wr),
        .req    (req),
        .rdata  (rdata1),
        .sram   (sram_port1),
        .stream (stream1),
        .busy   (busy[1])
    );

    fv_bank_sram #(
        .depth (depth)
    ) sram1 (
        .clk   (clk),
        .port  (sram_port1),
        .rdata (rdata1)
    );

    fv_stream_merge #(
        .fifo_depth (fifo_depth)
    ) merge (
        .clk   (clk),
        .reset (reset),
        .in0   (stream0),
        .in1   (stream1),
        .out   (out)
    );

endmodule

`default_nettype wire

// File: hdl/fv_stream_merge.sv
// Per-bank packet FIFOs and round-robin packet arbiter onto one output stream
`timescale 1ns/1ps
`default_nettype none

module fv_stream_merge #(
    parameter int fifo_depth = 32
) (
    input  logic                    clk,
    input  logic                    reset,
    input  fv_mem_pkg::fv_word_t    in0,
    input  fv_mem_pkg::fv_word_t    in1,
    output fv_mem_pkg::fv_word_t    out
);

    localparam int ptr_width = $clog2(fifo_depth);
    localparam int cnt_width = $clog2(fifo_depth + 1);

    fv_mem_pkg::merge_state_t state;

    fv_mem_pkg::fv_word_t   fifo_mem [2][fifo_depth];
    fv_mem_pkg::fv_word_t   in_word [2];
    fv_mem_pkg::fv_word_t   head [2];         // Next word of each bank, FIFO or bypass
    logic [ptr_width-1:0]   wr_ptr [2];
    logic [ptr_width-1:0]   rd_ptr [2];
    logic [cnt_width-1:0]   used [2];
    logic [cnt_width-1:0]   pkt_cnt [2];      // Packets waiting, counted by their sos word
    logic [1:0]             avail;
    logic [1:0]             pop;
    logic                   sel;              // Bank being sent
    logic                   last;             // Bank served last
    logic                   pick_ok;
    logic                   pick_bank;
    logic                   src;

    function automatic logic [ptr_width-1:0] next_ptr(input logic [ptr_width-1:0] ptr);
        return (ptr == ptr_width'(fifo_depth - 1)) ? '0 : ptr + 1'b1;
    endfunction

    // A bank sends its packet words back to back, so a packet whose sos is here
    // completes at least as fast as it is drained and may start at once
    always_comb begin
        in_word[0] = in0;
        in_word[1] = in1;
        for (int b = 0; b < 2; b++) begin
            head[b]  = (used[b] == '0) ? in_word[b] : fifo_mem[b][rd_ptr[b]];
            avail[b] = (pkt_cnt[b] != '0) || (in_word[b].valid && in_word[b].sos);
        end
    end

    always_comb begin
        pick_ok   = avail[~last] || avail[last];
        pick_bank = avail[~last] ? ~last : last;    // Other bank first
        src       = (state == fv_mem_pkg::merge_pick) ? pick_bank : sel;
        pop       = '0;
        if (state == fv_mem_pkg::merge_send || pick_ok) begin
            pop[src] = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        for (int b = 0; b < 2; b++) begin
            if (in_word[b].valid) begin
                fifo_mem[b][wr_ptr[b]] <= in_word[b];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= fv_mem_pkg::merge_pick;
            sel   <= 1'b0;
            last  <= 1'b1;    // Bank 0 goes first
            out   <= '0;
            for (int b = 0; b < 2; b++) begin
                wr_ptr[b]  <= '0;
                rd_ptr[b]  <= '0;
                used[b]    <= '0;
                pkt_cnt[b] <= '0;
            end
        end else begin
            for (int b = 0; b < 2; b++) begin
                if (in_word[b].valid) begin
                    wr_ptr[b] <= next_ptr(wr_ptr[b]);
                end
                if (pop[b]) begin
                    rd_ptr[b] <= next_ptr(rd_ptr[b]);
                end
                used[b]    <= used[b] + cnt_width'(in_word[b].valid) - cnt_width'(pop[b]);
                pkt_cnt[b] <= pkt_cnt[b]
                              + cnt_width'(in_word[b].valid && in_word[b].sos)
                              - cnt_width'(pop[b] && head[b].sos);
            end

            out <= '0;
            if (pop != 2'b00) begin
                out <= head[src];
            end

            case (state)
                fv_mem_pkg::merge_pick: begin
                    if (pick_ok) begin
                        sel  <= pick_bank;
                        last <= pick_bank;
                        if (!head[pick_bank].eos) begin
                            state <= fv_mem_pkg::merge_send;
                        end
                    end
                end
                fv_mem_pkg::merge_send: begin
                    if (head[sel].eos) begin
                        state <= fv_mem_pkg::merge_pick;
                    end
                end
                default: begin
                    state <= fv_mem_pkg::merge_pick;
                end
            endcase
        end
    end

endmodule

`default_nettype wire
